/* design/ex_alu.sv */
module ex_alu (
    input  ex_pkg::alu_fn_e alu_fn,
    input  ex_pkg::data_t   op_a,
    input  ex_pkg::data_t   op_b,
    output ex_pkg::data_t   result,
    output ex_pkg::flags_t  flags_new,
    output ex_pkg::flags_t  flags_we
);

    localparam int MSB = ex_pkg::DATA_W - 1;

    logic [ex_pkg::DATA_W:0]    sum;
    logic [ex_pkg::DATA_W:0]    diff;
    logic [ex_pkg::SHAMT_W-1:0] shamt;
    logic                       shift_ovf;
    logic                       add_ovf;
    logic                       sub_ovf;
    logic                       diff_zero;

    // extra top bit holds the carry out or the borrow.
    assign sum  = {1'b0, op_a} + {1'b0, op_b};
    assign diff = {1'b0, op_a} - {1'b0, op_b};

    assign shamt     = op_b[ex_pkg::SHAMT_W-1:0];
    assign shift_ovf = (op_b >= ex_pkg::data_t'(ex_pkg::DATA_W));
    assign diff_zero = (diff[MSB:0] == '0);

    // two's complement overflow on the sign bit.
    assign add_ovf = (op_a[MSB] == op_b[MSB]) && (sum[MSB] != op_a[MSB]);
    assign sub_ovf = (op_a[MSB] != op_b[MSB]) && (diff[MSB] != op_a[MSB]);

    always_comb begin
        result    = '0;
        flags_new = '0;
        flags_we  = '0;
        case (alu_fn)
            ex_pkg::FN_PASS: result = op_b;
            ex_pkg::FN_NOT:  result = ~op_a;
            ex_pkg::FN_AND:  result = op_a & op_b;
            ex_pkg::FN_OR:   result = op_a | op_b;
            ex_pkg::FN_XOR:  result = op_a ^ op_b;
            ex_pkg::FN_ADD: begin
                result                    = sum[MSB:0];
                flags_new[ex_pkg::FLAG_C] = sum[ex_pkg::DATA_W];
                flags_we[ex_pkg::FLAG_C]  = 1'b1;
            end
            ex_pkg::FN_SUB: begin
                result                    = diff[MSB:0];
                flags_new[ex_pkg::FLAG_C] = diff[ex_pkg::DATA_W];
                flags_we[ex_pkg::FLAG_C]  = 1'b1;
            end
            ex_pkg::FN_CMPU: begin
                flags_new[ex_pkg::FLAG_C] = diff[ex_pkg::DATA_W];
                flags_we[ex_pkg::FLAG_C]  = 1'b1;
            end
            ex_pkg::FN_SHL: begin
                result                    = shift_ovf ? '0 : op_a << shamt;
                flags_new[ex_pkg::FLAG_V] = shift_ovf;
                flags_we[ex_pkg::FLAG_V]  = 1'b1;
            end
            ex_pkg::FN_SHR: begin
                result                    = shift_ovf ? '0 : op_a >> shamt;
                flags_new[ex_pkg::FLAG_V] = shift_ovf;
                flags_we[ex_pkg::FLAG_V]  = 1'b1;
            end
            ex_pkg::FN_SAR: begin
                result = shift_ovf ? '0 : ex_pkg::data_t'($signed(op_a) >>> shamt);
                flags_new[ex_pkg::FLAG_N] = result[MSB];
                flags_new[ex_pkg::FLAG_V] = shift_ovf;
                flags_we[ex_pkg::FLAG_N]  = 1'b1;
                flags_we[ex_pkg::FLAG_V]  = 1'b1;
            end
            ex_pkg::FN_ADDS: begin
                result                    = sum[MSB:0];
                flags_new[ex_pkg::FLAG_N] = sum[MSB];
                flags_new[ex_pkg::FLAG_V] = add_ovf;
                flags_we[ex_pkg::FLAG_N]  = 1'b1;
                flags_we[ex_pkg::FLAG_V]  = 1'b1;
            end
            ex_pkg::FN_SUBS: begin
                result                    = diff[MSB:0];
                flags_new[ex_pkg::FLAG_N] = diff[MSB];
                flags_new[ex_pkg::FLAG_V] = sub_ovf;
                flags_we[ex_pkg::FLAG_N]  = 1'b1;
                flags_we[ex_pkg::FLAG_V]  = 1'b1;
            end
            ex_pkg::FN_CMPS: begin
                flags_new[ex_pkg::FLAG_N] = diff[MSB];
                flags_new[ex_pkg::FLAG_V] = sub_ovf;
                flags_we[ex_pkg::FLAG_N]  = 1'b1;
                flags_we[ex_pkg::FLAG_V]  = 1'b1;
            end
            // none forwards operand b and leaves every flag alone.
            default: result = op_b;
        endcase

        // every function except none writes Z; compares take it from the difference.
        if (alu_fn != ex_pkg::FN_NONE) begin
            flags_we[ex_pkg::FLAG_Z] = 1'b1;
            if (alu_fn == ex_pkg::FN_CMPU || alu_fn == ex_pkg::FN_CMPS) begin
                flags_new[ex_pkg::FLAG_Z] = diff_zero;
            end else begin
                flags_new[ex_pkg::FLAG_Z] = (result == '0);
            end
        end
    end

endmodule

/* design/ex_branch_unit.sv */
module ex_branch_unit (
    input  logic            iw_clk,
    input  logic            iw_rst,
    input  logic            stall,
    input  ex_pkg::opcode_e opc,
    input  ex_pkg::cc_e     cc,
    input  ex_pkg::addr_t   pc,
    input  ex_pkg::data_t   src_val,
    input  ex_pkg::imm_t    imm,
    input  ex_pkg::flags_t  flags_new,
    input  ex_pkg::flags_t  flags_we,
    output logic            branch_taken,
    output ex_pkg::addr_t   branch_pc
);

    ex_pkg::flags_t flags_q;
    ex_pkg::addr_t  target;
    logic           is_branch;
    logic           cond_met;
    logic           z;
    logic           n;
    logic           c;
    logic           v;

    // flags without a write strobe keep their value.
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            flags_q <= '0;
        end else if (!stall) begin
            flags_q <= (flags_q & ~flags_we) | (flags_new & flags_we);
        end
    end

    assign z = flags_q[ex_pkg::FLAG_Z];
    assign n = flags_q[ex_pkg::FLAG_N];
    assign c = flags_q[ex_pkg::FLAG_C];
    assign v = flags_q[ex_pkg::FLAG_V];

    always_comb begin
        case (cc)
            ex_pkg::CC_RA: cond_met = 1'b1;
            ex_pkg::CC_EQ: cond_met = z;
            ex_pkg::CC_NE: cond_met = ~z;
            ex_pkg::CC_LT: cond_met = n ^ v;
            ex_pkg::CC_GT: cond_met = ~z & ~(n ^ v);
            ex_pkg::CC_GE: cond_met = ~(n ^ v);
            ex_pkg::CC_LE: cond_met = z | (n ^ v);
            ex_pkg::CC_BT: cond_met = c;
            ex_pkg::CC_AT: cond_met = ~z & ~c;
            ex_pkg::CC_BE: cond_met = c | z;
            ex_pkg::CC_AE: cond_met = ~c;
            default:       cond_met = 1'b0;
        endcase
    end

    always_comb begin
        is_branch = 1'b1;
        case (opc)
            ex_pkg::OPC_JCC:  target = pc + src_val;
            ex_pkg::OPC_JCCI: target = {{(ex_pkg::ADDR_W - ex_pkg::IMM_W){1'b0}}, imm};
            ex_pkg::OPC_BCCI: begin
                target = pc + {{(ex_pkg::ADDR_W - ex_pkg::IMM_W){imm[ex_pkg::IMM_W-1]}}, imm};
            end
            default: begin
                is_branch = 1'b0;
                target    = '0;
            end
        endcase
    end

    assign branch_taken = is_branch & cond_met;
    assign branch_pc    = branch_taken ? target : '0;

endmodule

/* design/ex_operand_sel.sv */
module ex_operand_sel (
    input  ex_pkg::opcode_e opc,
    input  ex_pkg::data_t   src_val,
    input  ex_pkg::data_t   tgt_val,
    input  ex_pkg::imm_t    imm,
    output ex_pkg::alu_fn_e alu_fn,
    output ex_pkg::data_t   op_a,
    output ex_pkg::data_t   op_b,
    output ex_pkg::addr_t   mem_addr
);

    ex_pkg::data_t imm_zx;
    ex_pkg::data_t imm_sx;

    assign imm_zx = {{(ex_pkg::DATA_W - ex_pkg::IMM_W){1'b0}}, imm};
    assign imm_sx = {{(ex_pkg::DATA_W - ex_pkg::IMM_W){imm[ex_pkg::IMM_W-1]}}, imm};

    always_comb begin
        alu_fn   = ex_pkg::FN_NONE;
        op_a     = tgt_val;
        op_b     = src_val;
        mem_addr = '0;
        case (opc)
            ex_pkg::OPC_MOV:   alu_fn = ex_pkg::FN_PASS;
            ex_pkg::OPC_ADD:   alu_fn = ex_pkg::FN_ADD;
            ex_pkg::OPC_SUB:   alu_fn = ex_pkg::FN_SUB;
            ex_pkg::OPC_NOT:   alu_fn = ex_pkg::FN_NOT;
            ex_pkg::OPC_AND:   alu_fn = ex_pkg::FN_AND;
            ex_pkg::OPC_OR:    alu_fn = ex_pkg::FN_OR;
            ex_pkg::OPC_XOR:   alu_fn = ex_pkg::FN_XOR;
            ex_pkg::OPC_SHL:   alu_fn = ex_pkg::FN_SHL;
            ex_pkg::OPC_SHR:   alu_fn = ex_pkg::FN_SHR;
            ex_pkg::OPC_CMP:   alu_fn = ex_pkg::FN_CMPU;
            ex_pkg::OPC_ADDS:  alu_fn = ex_pkg::FN_ADDS;
            ex_pkg::OPC_SUBS:  alu_fn = ex_pkg::FN_SUBS;
            ex_pkg::OPC_SARS:  alu_fn = ex_pkg::FN_SAR;
            ex_pkg::OPC_CMPS:  alu_fn = ex_pkg::FN_CMPS;
            ex_pkg::OPC_MOVI:  begin alu_fn = ex_pkg::FN_PASS; op_b = imm_zx; end
            ex_pkg::OPC_ADDI:  begin alu_fn = ex_pkg::FN_ADD;  op_b = imm_zx; end
            ex_pkg::OPC_SUBI:  begin alu_fn = ex_pkg::FN_SUB;  op_b = imm_zx; end
            ex_pkg::OPC_ANDI:  begin alu_fn = ex_pkg::FN_AND;  op_b = imm_zx; end
            ex_pkg::OPC_ORI:   begin alu_fn = ex_pkg::FN_OR;   op_b = imm_zx; end
            ex_pkg::OPC_XORI:  begin alu_fn = ex_pkg::FN_XOR;  op_b = imm_zx; end
            ex_pkg::OPC_SHLI:  begin alu_fn = ex_pkg::FN_SHL;  op_b = imm_zx; end
            ex_pkg::OPC_SHRI:  begin alu_fn = ex_pkg::FN_SHR;  op_b = imm_zx; end
            ex_pkg::OPC_CMPI:  begin alu_fn = ex_pkg::FN_CMPU; op_b = imm_zx; end
            ex_pkg::OPC_MOVIS: begin alu_fn = ex_pkg::FN_PASS; op_b = imm_sx; end
            ex_pkg::OPC_ADDIS: begin alu_fn = ex_pkg::FN_ADDS; op_b = imm_sx; end
            ex_pkg::OPC_SUBIS: begin alu_fn = ex_pkg::FN_SUBS; op_b = imm_sx; end
            ex_pkg::OPC_SARIS: begin alu_fn = ex_pkg::FN_SAR;  op_b = imm_sx; end
            ex_pkg::OPC_CMPIS: begin alu_fn = ex_pkg::FN_CMPS; op_b = imm_sx; end
            // memory ops bypass the flags; store data rides on operand b.
            ex_pkg::OPC_LD: begin
                op_a     = '0;
                op_b     = '0;
                mem_addr = src_val;
            end
            ex_pkg::OPC_ST: begin
                op_a     = '0;
                mem_addr = tgt_val;
            end
            ex_pkg::OPC_STI: begin
                op_a     = '0;
                op_b     = imm_zx;
                mem_addr = tgt_val;
            end
            default: begin
                op_a = '0;
                op_b = '0;
            end
        endcase
    end

endmodule

/* design/ex_pkg.sv */
package ex_pkg;

    localparam int DATA_W  = 24;
    localparam int ADDR_W  = 24;
    localparam int IMM_W   = 12;
    localparam int SHAMT_W = 5;
    localparam int FLAG_W  = 4;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [IMM_W-1:0]  imm_t;
    typedef logic [FLAG_W-1:0] flags_t;

    // bit positions inside flags_t.
    localparam int FLAG_Z = 0;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 2;
    localparam int FLAG_V = 3;

    // opcodes are grouped by class in the upper bits.
    typedef enum logic [5:0] {
        OPC_NOP   = 6'h00,
        OPC_MOV   = 6'h01,
        OPC_ADD   = 6'h02,
        OPC_SUB   = 6'h03,
        OPC_NOT   = 6'h04,
        OPC_AND   = 6'h05,
        OPC_OR    = 6'h06,
        OPC_XOR   = 6'h07,
        OPC_SHL   = 6'h08,
        OPC_SHR   = 6'h09,
        OPC_CMP   = 6'h0a,
        OPC_ADDS  = 6'h10,
        OPC_SUBS  = 6'h11,
        OPC_SARS  = 6'h12,
        OPC_CMPS  = 6'h13,
        OPC_MOVI  = 6'h18,
        OPC_ADDI  = 6'h19,
        OPC_SUBI  = 6'h1a,
        OPC_ANDI  = 6'h1b,
        OPC_ORI   = 6'h1c,
        OPC_XORI  = 6'h1d,
        OPC_SHLI  = 6'h1e,
        OPC_SHRI  = 6'h1f,
        OPC_CMPI  = 6'h20,
        OPC_MOVIS = 6'h28,
        OPC_ADDIS = 6'h29,
        OPC_SUBIS = 6'h2a,
        OPC_SARIS = 6'h2b,
        OPC_CMPIS = 6'h2c,
        OPC_LD    = 6'h30,
        OPC_ST    = 6'h31,
        OPC_STI   = 6'h32,
        OPC_JCC   = 6'h38,
        OPC_JCCI  = 6'h39,
        OPC_BCCI  = 6'h3a
    } opcode_e;

    // codes 11 to 15 are never taken.
    typedef enum logic [3:0] {
        CC_RA = 4'd0,
        CC_EQ = 4'd1,
        CC_NE = 4'd2,
        CC_LT = 4'd3,
        CC_GT = 4'd4,
        CC_GE = 4'd5,
        CC_LE = 4'd6,
        CC_BT = 4'd7,
        CC_AT = 4'd8,
        CC_BE = 4'd9,
        CC_AE = 4'd10
    } cc_e;

    typedef enum logic [3:0] {
        FN_PASS, FN_ADD, FN_SUB, FN_NOT, FN_AND, FN_OR, FN_XOR, FN_SHL,
        FN_SHR, FN_SAR, FN_ADDS, FN_SUBS, FN_CMPU, FN_CMPS, FN_NONE
    } alu_fn_e;

endpackage

/* design/ex_stage.sv */
module ex_stage (
    input  logic            iw_clk,
    input  logic            iw_rst,
    input  logic            stall,
    input  ex_pkg::addr_t   pc,
    input  ex_pkg::opcode_e opc,
    input  ex_pkg::cc_e     cc,
    input  ex_pkg::imm_t    imm,
    input  ex_pkg::data_t   src_val,
    input  ex_pkg::data_t   tgt_val,
    input  logic [4:0]      tgt,
    input  logic            tgt_we,
    output ex_pkg::addr_t   ex_pc,
    output ex_pkg::opcode_e ex_opc,
    output logic [4:0]      ex_tgt,
    output logic            ex_tgt_we,
    output ex_pkg::addr_t   ex_addr,
    output ex_pkg::data_t   ex_result,
    output logic            branch_taken,
    output ex_pkg::addr_t   branch_pc
);

    ex_pkg::alu_fn_e alu_fn;
    ex_pkg::data_t   op_a;
    ex_pkg::data_t   op_b;
    ex_pkg::addr_t   mem_addr;
    ex_pkg::data_t   result;
    ex_pkg::flags_t  flags_new;
    ex_pkg::flags_t  flags_we;

    ex_operand_sel i_operand_sel (
        .opc      (opc),
        .src_val  (src_val),
        .tgt_val  (tgt_val),
        .imm      (imm),
        .alu_fn   (alu_fn),
        .op_a     (op_a),
        .op_b     (op_b),
        .mem_addr (mem_addr)
    );

    ex_alu i_alu (
        .alu_fn    (alu_fn),
        .op_a      (op_a),
        .op_b      (op_b),
        .result    (result),
        .flags_new (flags_new),
        .flags_we  (flags_we)
    );

    ex_branch_unit i_branch_unit (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .stall        (stall),
        .opc          (opc),
        .cc           (cc),
        .pc           (pc),
        .src_val      (src_val),
        .imm          (imm),
        .flags_new    (flags_new),
        .flags_we     (flags_we),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc)
    );

    // the register toward the memory stage captures on the same edge as the flags.
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            ex_pc     <= '0;
            ex_opc    <= ex_pkg::OPC_NOP;
            ex_tgt    <= '0;
            ex_tgt_we <= 1'b0;
            ex_addr   <= '0;
            ex_result <= '0;
        end else if (!stall) begin
            ex_pc     <= pc;
            ex_opc    <= opc;
            ex_tgt    <= tgt;
            ex_tgt_we <= tgt_we;
            ex_addr   <= mem_addr;
            ex_result <= result;
        end
    end

endmodule

/* flist.f */
design/ex_pkg.sv
design/ex_operand_sel.sv
design/ex_alu.sv
design/ex_branch_unit.sv
design/ex_stage.sv
sim/ex_checker.sv
sim/tb_ex_stage.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_ex_stage -Mdir obj_dir \
    -o tb_ex_stage -f flist.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_ex_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
    exit 0
fi
exit 1

/* sim/ex_checker.sv */
module ex_checker (
    input  logic            iw_clk,
    input  logic            iw_rst,
    input  logic            stall,
    input  ex_pkg::addr_t   pc,
    input  ex_pkg::opcode_e opc,
    input  ex_pkg::cc_e     cc,
    input  ex_pkg::imm_t    imm,
    input  ex_pkg::data_t   src_val,
    input  ex_pkg::data_t   tgt_val,
    input  logic [4:0]      tgt,
    input  logic            tgt_we,
    input  ex_pkg::addr_t   ex_pc,
    input  ex_pkg::opcode_e ex_opc,
    input  logic [4:0]      ex_tgt,
    input  logic            ex_tgt_we,
    input  ex_pkg::addr_t   ex_addr,
    input  ex_pkg::data_t   ex_result,
    input  logic            branch_taken,
    input  ex_pkg::addr_t   branch_pc,
    output int              value_errs,
    output int              other_errs
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam ex_pkg::flags_t MASK_Z = 4'b0001 << ex_pkg::FLAG_Z;
    localparam ex_pkg::flags_t MASK_N = 4'b0001 << ex_pkg::FLAG_N;
    localparam ex_pkg::flags_t MASK_C = 4'b0001 << ex_pkg::FLAG_C;
    localparam ex_pkg::flags_t MASK_V = 4'b0001 << ex_pkg::FLAG_V;

    int              n_value = 0;
    int              n_other = 0;
    logic            primed = 1'b0;
    ex_pkg::flags_t  model_flags = '0;
    ex_pkg::addr_t   exp_pc = '0;
    ex_pkg::opcode_e exp_opc = ex_pkg::OPC_NOP;
    logic [4:0]      exp_tgt = '0;
    logic            exp_tgt_we = 1'b0;
    ex_pkg::addr_t   exp_addr = '0;
    ex_pkg::data_t   exp_result = '0;
    logic            exp_taken;
    ex_pkg::addr_t   exp_target;
    ex_pkg::data_t   r_res;
    ex_pkg::addr_t   r_addr;
    ex_pkg::flags_t  r_fval;
    ex_pkg::flags_t  r_fmask;

    assign value_errs = n_value;
    assign other_errs = n_other;

    task automatic check_value(input string name, input logic [23:0] got,
                               input logic [23:0] exp);
        if (got !== exp) begin
            n_value++;
            $display("FAIL %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic int sext32(input ex_pkg::data_t v);
        return {{8{v[23]}}, v};
    endfunction

    function automatic void ref_exec(
        input  ex_pkg::opcode_e o,
        input  ex_pkg::data_t   a,
        input  ex_pkg::data_t   src,
        input  ex_pkg::imm_t    i,
        output ex_pkg::data_t   res,
        output ex_pkg::addr_t   addr,
        output ex_pkg::flags_t  fval,
        output ex_pkg::flags_t  fmask
    );
        ex_pkg::data_t zx;
        ex_pkg::data_t sx;
        ex_pkg::data_t b;
        logic [24:0]   wide;
        int            s;
        logic          cmp;
        zx    = {12'h000, i};
        sx    = {{12{i[11]}}, i};
        res   = '0;
        addr  = '0;
        fval  = '0;
        fmask = '0;
        cmp   = 1'b0;
        case (o)
            ex_pkg::OPC_MOVI, ex_pkg::OPC_ADDI, ex_pkg::OPC_SUBI, ex_pkg::OPC_ANDI,
            ex_pkg::OPC_ORI, ex_pkg::OPC_XORI, ex_pkg::OPC_SHLI, ex_pkg::OPC_SHRI,
            ex_pkg::OPC_CMPI: b = zx;
            ex_pkg::OPC_MOVIS, ex_pkg::OPC_ADDIS, ex_pkg::OPC_SUBIS, ex_pkg::OPC_SARIS,
            ex_pkg::OPC_CMPIS: b = sx;
            default: b = src;
        endcase
        case (o)
            ex_pkg::OPC_MOV, ex_pkg::OPC_MOVI, ex_pkg::OPC_MOVIS: begin
                res   = b;
                fmask = MASK_Z;
            end
            ex_pkg::OPC_NOT: begin
                res   = ~a;
                fmask = MASK_Z;
            end
            ex_pkg::OPC_AND, ex_pkg::OPC_ANDI: begin
                res   = a & b;
                fmask = MASK_Z;
            end
            ex_pkg::OPC_OR, ex_pkg::OPC_ORI: begin
                res   = a | b;
                fmask = MASK_Z;
            end
            ex_pkg::OPC_XOR, ex_pkg::OPC_XORI: begin
                res   = a ^ b;
                fmask = MASK_Z;
            end
            ex_pkg::OPC_ADD, ex_pkg::OPC_ADDI: begin
                wide                 = {1'b0, a} + {1'b0, b};
                res                  = wide[23:0];
                fval[ex_pkg::FLAG_C] = wide[24];
                fmask                = MASK_Z | MASK_C;
            end
            ex_pkg::OPC_SUB, ex_pkg::OPC_SUBI: begin
                res                  = a - b;
                fval[ex_pkg::FLAG_C] = (a < b);
                fmask                = MASK_Z | MASK_C;
            end
            ex_pkg::OPC_CMP, ex_pkg::OPC_CMPI: begin
                cmp                  = 1'b1;
                fval[ex_pkg::FLAG_Z] = (a == b);
                fval[ex_pkg::FLAG_C] = (a < b);
                fmask                = MASK_Z | MASK_C;
            end
            ex_pkg::OPC_SHL, ex_pkg::OPC_SHLI: begin
                res                  = (b >= 24'd24) ? '0 : a << b;
                fval[ex_pkg::FLAG_V] = (b >= 24'd24);
                fmask                = MASK_Z | MASK_V;
            end
            ex_pkg::OPC_SHR, ex_pkg::OPC_SHRI: begin
                res                  = (b >= 24'd24) ? '0 : a >> b;
                fval[ex_pkg::FLAG_V] = (b >= 24'd24);
                fmask                = MASK_Z | MASK_V;
            end
            // logical shift with the vacated top bits refilled from the sign.
            ex_pkg::OPC_SARS, ex_pkg::OPC_SARIS: begin
                res = (b >= 24'd24) ? '0 : (a >> b) | (a[23] ? ~(24'hffffff >> b) : 24'h0);
                fval[ex_pkg::FLAG_N] = res[23];
                fval[ex_pkg::FLAG_V] = (b >= 24'd24);
                fmask                = MASK_Z | MASK_N | MASK_V;
            end
            ex_pkg::OPC_ADDS, ex_pkg::OPC_ADDIS: begin
                s                    = sext32(a) + sext32(b);
                res                  = s[23:0];
                fval[ex_pkg::FLAG_N] = res[23];
                fval[ex_pkg::FLAG_V] = (s > 8388607) || (s < -8388608);
                fmask                = MASK_Z | MASK_N | MASK_V;
            end
            ex_pkg::OPC_SUBS, ex_pkg::OPC_SUBIS: begin
                s                    = sext32(a) - sext32(b);
                res                  = s[23:0];
                fval[ex_pkg::FLAG_N] = res[23];
                fval[ex_pkg::FLAG_V] = (s > 8388607) || (s < -8388608);
                fmask                = MASK_Z | MASK_N | MASK_V;
            end
            ex_pkg::OPC_CMPS, ex_pkg::OPC_CMPIS: begin
                s                    = sext32(a) - sext32(b);
                cmp                  = 1'b1;
                fval[ex_pkg::FLAG_Z] = (a == b);
                fval[ex_pkg::FLAG_N] = s[23];
                fval[ex_pkg::FLAG_V] = (s > 8388607) || (s < -8388608);
                fmask                = MASK_Z | MASK_N | MASK_V;
            end
            ex_pkg::OPC_LD: addr = src;
            ex_pkg::OPC_ST: begin
                addr = a;
                res  = src;
            end
            ex_pkg::OPC_STI: begin
                addr = a;
                res  = zx;
            end
            default: res = '0;
        endcase
        if (fmask[ex_pkg::FLAG_Z] && !cmp) begin
            fval[ex_pkg::FLAG_Z] = (res == '0);
        end
    endfunction

    function automatic logic cond_holds(input ex_pkg::cc_e c_in, input ex_pkg::flags_t f);
        logic z;
        logic n;
        logic c;
        logic v;
        z = f[ex_pkg::FLAG_Z];
        n = f[ex_pkg::FLAG_N];
        c = f[ex_pkg::FLAG_C];
        v = f[ex_pkg::FLAG_V];
        case (c_in)
            ex_pkg::CC_RA: return 1'b1;
            ex_pkg::CC_EQ: return z;
            ex_pkg::CC_NE: return !z;
            ex_pkg::CC_LT: return n != v;
            ex_pkg::CC_GT: return !z && (n == v);
            ex_pkg::CC_GE: return n == v;
            ex_pkg::CC_LE: return z || (n != v);
            ex_pkg::CC_BT: return c;
            ex_pkg::CC_AT: return !c && !z;
            ex_pkg::CC_BE: return c || z;
            ex_pkg::CC_AE: return !c;
            default:       return 1'b0;
        endcase
    endfunction

    function automatic ex_pkg::addr_t branch_target(input ex_pkg::opcode_e o,
                                                    input ex_pkg::addr_t p,
                                                    input ex_pkg::data_t s,
                                                    input ex_pkg::imm_t i);
        case (o)
            ex_pkg::OPC_JCC:  return p + s;
            ex_pkg::OPC_JCCI: return {12'h000, i};
            ex_pkg::OPC_BCCI: return p + {{12{i[11]}}, i};
            default:          return '0;
        endcase
    endfunction

    always @(posedge iw_clk) begin
        if (iw_rst) begin
            model_flags = '0;
            exp_pc      = '0;
            exp_opc     = ex_pkg::OPC_NOP;
            exp_tgt     = '0;
            exp_tgt_we  = 1'b0;
            exp_addr    = '0;
            exp_result  = '0;
        end
        // the first edge is where the reset lands on the register.
        if (primed) begin
            if ($isunknown({ex_pc, ex_opc, ex_tgt, ex_tgt_we, ex_addr, ex_result,
                            branch_taken, branch_pc})) begin
                n_other++;
                $display("DUT outputs carry unknown bits at %0t", $time);
            end
            check_value("ex_pc", ex_pc, exp_pc);
            check_value("ex_opc", 24'(ex_opc), 24'(exp_opc));
            check_value("ex_tgt", 24'(ex_tgt), 24'(exp_tgt));
            check_value("ex_tgt_we", 24'(ex_tgt_we), 24'(exp_tgt_we));
            check_value("ex_addr", ex_addr, exp_addr);
            check_value("ex_result", ex_result, exp_result);
            exp_taken  = (opc inside {ex_pkg::OPC_JCC, ex_pkg::OPC_JCCI, ex_pkg::OPC_BCCI})
                         && cond_holds(cc, model_flags);
            exp_target = exp_taken ? branch_target(opc, pc, src_val, imm) : '0;
            check_value("branch_taken", 24'(branch_taken), 24'(exp_taken));
            check_value("branch_pc", branch_pc, exp_target);
        end
        primed = 1'b1;
        if (!iw_rst && !stall) begin
            ref_exec(opc, tgt_val, src_val, imm, r_res, r_addr, r_fval, r_fmask);
            model_flags = (model_flags & ~r_fmask) | (r_fval & r_fmask);
            exp_pc      = pc;
            exp_opc     = opc;
            exp_tgt     = tgt;
            exp_tgt_we  = tgt_we;
            exp_addr    = r_addr;
            exp_result  = r_res;
        end
    end

endmodule

/* sim/tb_ex_stage.sv */
module tb_ex_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_INSTR    = 3000;
    localparam int RST_CYCLES = 8;
    localparam int MAX_CYCLES = N_INSTR + RST_CYCLES + N_INSTR / 4 + 100;
    // one bit per opcode code that the decoder knows.
    localparam logic [63:0] VALID_OPC = 64'h0707_1f01_ff0f_07ff;

    logic            iw_clk = 1'b0;
    logic            iw_rst;
    logic            stall;
    ex_pkg::addr_t   pc;
    ex_pkg::opcode_e opc;
    ex_pkg::cc_e     cc;
    ex_pkg::imm_t    imm;
    ex_pkg::data_t   src_val;
    ex_pkg::data_t   tgt_val;
    logic [4:0]      tgt;
    logic            tgt_we;
    ex_pkg::addr_t   ex_pc;
    ex_pkg::opcode_e ex_opc;
    logic [4:0]      ex_tgt;
    logic            ex_tgt_we;
    ex_pkg::addr_t   ex_addr;
    ex_pkg::data_t   ex_result;
    logic            branch_taken;
    ex_pkg::addr_t   branch_pc;
    int              value_errs;
    int              other_errs;
    logic [31:0]     rng = 32'hef01619d;
    int              issued = 0;
    int              cycles = 0;

    always #10 iw_clk = ~iw_clk;

    ex_stage i_dut (.*);

    ex_checker i_checker (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // mostly random words, with boundary values mixed in.
    function automatic ex_pkg::data_t shape_data(input logic [31:0] r);
        if (r[30:28] != 3'd0) begin
            return r[31:8];
        end
        case (r[27:25])
            3'd0:    return 24'h000000;
            3'd1:    return 24'hffffff;
            3'd2:    return 24'd23;
            3'd3:    return 24'd24;
            3'd4:    return 24'h800000;
            3'd5:    return 24'h7fffff;
            3'd6:    return 24'h000001;
            default: return 24'h800001;
        endcase
    endfunction

    function automatic ex_pkg::imm_t shape_imm(input logic [31:0] r);
        if (r[30:28] != 3'd0) begin
            return r[31:20];
        end
        case (r[26:25])
            2'd0:    return 12'h017;
            2'd1:    return 12'h018;
            2'd2:    return 12'hfff;
            default: return 12'h800;
        endcase
    endfunction

    task automatic drive_instr();
        logic [5:0] code;
        rng   = lcg_next(rng);
        stall = (rng[31:29] == 3'd0);
        rng   = lcg_next(rng);
        code  = rng[31:26];
        while (!VALID_OPC[code]) begin
            rng  = lcg_next(rng);
            code = rng[31:26];
        end
        opc     = ex_pkg::opcode_e'(code);
        rng     = lcg_next(rng);
        cc      = ex_pkg::cc_e'(rng[31:28]);
        tgt     = rng[27:23];
        tgt_we  = rng[22];
        rng     = lcg_next(rng);
        pc      = rng[31:8];
        rng     = lcg_next(rng);
        src_val = shape_data(rng);
        rng     = lcg_next(rng);
        tgt_val = shape_data(rng);
        rng     = lcg_next(rng);
        imm     = shape_imm(rng);
        // keep half of the shifts below the width so they move bits.
        if (rng[19] && (opc inside {ex_pkg::OPC_SHL, ex_pkg::OPC_SHR, ex_pkg::OPC_SARS,
                                    ex_pkg::OPC_SHLI, ex_pkg::OPC_SHRI,
                                    ex_pkg::OPC_SARIS})) begin
            src_val = {19'h0, src_val[4:0]};
            imm     = {7'h0, imm[4:0]};
        end
    endtask

    task automatic print_counts();
        $display("closing report: %0d value errors, %0d other errors", value_errs, other_errs);
    endtask

    always @(posedge iw_clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            print_counts();
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        iw_rst  = 1'b1;
        stall   = 1'b0;
        pc      = 24'h000100;
        opc     = ex_pkg::OPC_JCC;
        cc      = ex_pkg::CC_EQ;
        imm     = '0;
        src_val = 24'h000123;
        tgt_val = '0;
        tgt     = 5'd3;
        tgt_we  = 1'b1;
        repeat (RST_CYCLES) @(posedge iw_clk);
        @(negedge iw_clk);
        iw_rst = 1'b0;
        while (issued < N_INSTR) begin
            drive_instr();
            if (!stall) begin
                issued++;
            end
            @(negedge iw_clk);
        end
        stall = 1'b0;
        opc   = ex_pkg::OPC_NOP;
        @(posedge iw_clk);
        @(negedge iw_clk);
        print_counts();
        if (value_errs == 0 && other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
